//--- all.f
rtl/fir_pkg.sv
rtl/tap_delay_line.sv
rtl/mac_lane.sv
rtl/lane_combiner.sv
rtl/serial_fir_top.sv
tb/serial_fir_assert.sv
tb/serial_fir_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass message in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module serial_fir_tb -Mdir obj_dir -f all.f \
  && ./obj_dir/Vserial_fir_tb +verilator+error+limit+1000 \
     | tee /dev/stderr | grep -q "TESTS PASSED" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- tb/serial_fir_tb.sv
`timescale 1ns/1ps
`default_nettype none

module serial_fir_tb;

  localparam int num_lanes      = 2;
  localparam int taps_per_lane  = 4;
  localparam int reset_cycles   = 8;
  localparam int zero_frames    = 4;
  localparam int impulse_frames = 10;
  localparam int random_frames  = 200;
  localparam int stall_frames   = 12;
  localparam int full_frames    = 8;   // per polarity
  localparam int flush_frames   = 3;
  localparam int total_frames   = zero_frames + impulse_frames + random_frames
                                  + stall_frames + 2 * full_frames + flush_frames;
  localparam int cycle_limit    = 2500;  // ~246 frames of 4 cycles, stalls, reset

  logic             clk;
  logic             reset;
  logic             clk_enable;
  fir_pkg::sample_t filter_in;
  fir_pkg::acc_t    filter_out;

  int cycles = 0;
  int errors;
  int checks;
  int min_checks;

  serial_fir_top #(
    .num_lanes     (num_lanes),
    .taps_per_lane (taps_per_lane)
  ) i_dut (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (clk_enable),
    .filter_in  (filter_in),
    .filter_out (filter_out)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout, the run did not finish within %0d cycles", cycle_limit);
      $display("TESTS FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////////////////////////////////////////

  // returns on the next edge that sees clk_enable high
  task automatic wait_enabled_edge(input bit stall);
    bit done;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      done = clk_enable;
      if (stall) begin
        clk_enable <= ($urandom_range(0, 3) != 0);  // random low stretches
      end else begin
        clk_enable <= 1'b1;
      end
    end
  endtask

  // called just after a capture edge, sample held for the whole frame
  task automatic send_frame(input fir_pkg::sample_t sample, input bit stall);
    filter_in <= sample;
    repeat (taps_per_lane) wait_enabled_edge(stall);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test phases
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk        = 1'b0;
    reset      = 1'b1;
    clk_enable = 1'b0;
    filter_in  = '0;
    void'($urandom(32'ha36c_b78b));

    repeat (reset_cycles) @(posedge clk);
    reset      <= 1'b0;
    clk_enable <= 1'b1;
    wait_enabled_edge(1'b0);  // first capture takes the idle zero

    repeat (zero_frames) send_frame('0, 1'b0);

    // impulse walks the coefficients out
    send_frame(16'h4000, 1'b0);
    repeat (impulse_frames - 1) send_frame('0, 1'b0);

    repeat (random_frames) send_frame(fir_pkg::sample_t'($urandom), 1'b0);
    repeat (stall_frames) send_frame(fir_pkg::sample_t'($urandom), 1'b1);

    // full scale both ways
    repeat (full_frames) send_frame(16'h7fff, 1'b0);
    repeat (full_frames) send_frame(16'h8000, 1'b0);

    repeat (flush_frames) send_frame('0, 1'b0);
    repeat (2) @(posedge clk);

    checks     = i_dut.i_assert.checks;
    min_checks = total_frames * taps_per_lane;  // at least every enabled edge
    errors     = i_dut.i_assert.value_errors + i_dut.i_assert.hold_errors
                 + i_dut.i_assert.reset_errors;

    $display("output checks %0d, value errors %0d, hold errors %0d, reset errors %0d",
             checks, i_dut.i_assert.value_errors, i_dut.i_assert.hold_errors,
             i_dut.i_assert.reset_errors);
    if (errors == 0 && checks >= min_checks) begin
      $display("TESTS PASSED");
    end else begin
      if (checks < min_checks) begin
        $display("only %0d output comparisons passed, at least %0d were due",
                 checks, min_checks);
      end
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/serial_fir_assert.sv
`timescale 1ns/1ps
`default_nettype none

module serial_fir_assert (
  input logic             clk,
  input logic             reset,
  input logic             clk_enable,
  input fir_pkg::sample_t filter_in,
  input fir_pkg::acc_t    filter_out
);

  localparam int num_taps = fir_pkg::num_coeffs;

  fir_pkg::sample_t hist [num_taps];  // hist[0] is the newest capture
  longint           exp_pipe [2];     // convolutions waiting for the output
  fir_pkg::acc_t    exp_out;
  int               en_count;         // enabled edges since reset
  logic             capture;

  int checks       = 0;
  int value_errors = 0;
  int hold_errors  = 0;
  int reset_errors = 0;

  // every fourth enabled edge takes a sample, starting with the first
  assign capture = clk_enable && ((en_count % 4) == 0);

  // exact sum over the taps, newest sample on coefficient 0
  function automatic longint convolve(input fir_pkg::sample_t newest);
    longint sum;
    sum = longint'(fir_pkg::coeff_table[0]) * longint'(newest);
    for (int k = 1; k < num_taps; k++) begin
      sum += longint'(fir_pkg::coeff_table[k]) * longint'(hist[k-1]);
    end
    return sum;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      en_count <= 0;
      hist     <= '{default: '0};
      exp_pipe <= '{default: 0};
      exp_out  <= '0;
    end else if (clk_enable) begin
      en_count <= en_count + 1;
      if (capture) begin
        hist[0] <= filter_in;
        for (int k = 1; k < num_taps; k++) begin
          hist[k] <= hist[k-1];
        end
        exp_pipe[0] <= convolve(filter_in);
        exp_pipe[1] <= exp_pipe[0];
        exp_out     <= fir_pkg::acc_t'(exp_pipe[1]);  // two frames behind the capture
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks on the top ports
  ////////////////////////////////////////////////////////////////////////////

  output_matches_model: assert property (@(posedge clk) disable iff (reset)
    filter_out == exp_out)
    checks++;  // edges where the output agreed with the model
  else begin
    value_errors++;
    $error("Mismatch filter_out=%h expected=%h", $sampled(filter_out), $sampled(exp_out));
  end

  // stalls and the slots between captures leave the output alone
  output_holds: assert property (@(posedge clk) disable iff (reset)
    !capture |=> $stable(filter_out))
  else begin
    hold_errors++;
    $error("filter_out changed on an edge that is not an output update");
  end

  zero_after_reset: assert property (@(posedge clk)
    $fell(reset) |-> filter_out == '0)
  else begin
    reset_errors++;
    $error("Mismatch filter_out=%h expected=%h after reset", $sampled(filter_out), 33'h0);
  end

endmodule

bind serial_fir_top serial_fir_assert i_assert (
  .clk        (clk),
  .reset      (reset),
  .clk_enable (clk_enable),
  .filter_in  (filter_in),
  .filter_out (filter_out)
);

`default_nettype wire

//--- rtl/serial_fir_top.sv
`timescale 1ns/1ps
`default_nettype none

module serial_fir_top #(
  parameter int num_lanes     = 2,
  parameter int taps_per_lane = 4
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             clk_enable,
  input  fir_pkg::sample_t filter_in,   // sfix16_En15
  output fir_pkg::acc_t    filter_out   // sfix33_En31
);

  fir_pkg::slot_info_t              slot_info;
  fir_pkg::sample_t [num_lanes-1:0] lane_taps;
  fir_pkg::acc_t [num_lanes-1:0]    lane_accs;

  ////////////////////////////////////////////////////////////////////////////
  // slot counter and taps
  ////////////////////////////////////////////////////////////////////////////

  tap_delay_line #(
    .num_lanes     (num_lanes),
    .taps_per_lane (taps_per_lane)
  ) i_tap_delay_line (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (clk_enable),
    .filter_in  (filter_in),
    .slot_info  (slot_info),
    .lane_taps  (lane_taps)
  );

  // one serial partition per lane
  for (genvar l = 0; l < num_lanes; l++) begin : g_lane
    mac_lane #(
      .lane_index    (l),
      .taps_per_lane (taps_per_lane)
    ) i_mac_lane (
      .clk       (clk),
      .reset     (reset),
      .slot_info (slot_info),
      .tap       (lane_taps[l]),
      .acc       (lane_accs[l])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // final sum and output
  ////////////////////////////////////////////////////////////////////////////

  lane_combiner #(
    .num_lanes (num_lanes)
  ) i_lane_combiner (
    .clk        (clk),
    .reset      (reset),
    .slot_info  (slot_info),
    .lane_accs  (lane_accs),
    .filter_out (filter_out)
  );

endmodule

`default_nettype wire

//--- rtl/lane_combiner.sv
`timescale 1ns/1ps
`default_nettype none

module lane_combiner #(
  parameter int num_lanes = 2
) (
  input  logic                             clk,
  input  logic                             reset,
  input  fir_pkg::slot_info_t              slot_info,
  input  fir_pkg::acc_t [num_lanes-1:0]    lane_accs,
  output fir_pkg::acc_t                    filter_out
);

  fir_pkg::acc_t lane_sum;
  fir_pkg::acc_t final_sum;
  fir_pkg::acc_t output_reg;

  ////////////////////////////////////////////////////////////////////////////
  // lane sum
  ////////////////////////////////////////////////////////////////////////////

  // partial sums are complete while the lanes start the next frame
  always_comb begin
    lane_sum = '0;
    for (int l = 0; l < num_lanes; l++) begin
      lane_sum = lane_sum + lane_accs[l];
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      final_sum <= '0;
    end else if (slot_info.first) begin
      final_sum <= lane_sum;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////////////////////

  // updates once per frame, together with the sample capture
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      output_reg <= '0;
    end else if (slot_info.last) begin
      output_reg <= final_sum;
    end
  end

  assign filter_out = output_reg;  // sfix33_En31

endmodule

`default_nettype wire

//--- rtl/mac_lane.sv
`timescale 1ns/1ps
`default_nettype none

module mac_lane #(
  parameter int lane_index    = 0,
  parameter int taps_per_lane = 4
) (
  input  logic                clk,
  input  logic                reset,
  input  fir_pkg::slot_info_t slot_info,
  input  fir_pkg::sample_t    tap,
  output fir_pkg::acc_t       acc
);

  localparam int base_index = lane_index * taps_per_lane;  // first coeff of this lane
  localparam int full_w     = fir_pkg::sample_w + fir_pkg::coeff_w;

  fir_pkg::coeff_t                       coeff;
  logic signed [full_w-1:0]              mul_full;
  logic signed [fir_pkg::product_w-1:0]  product;
  fir_pkg::acc_t                         product_ext;
  fir_pkg::acc_t                         acc_sum;
  fir_pkg::acc_t                         acc_q;

  ////////////////////////////////////////////////////////////////////////////
  // coefficient select and multiply
  ////////////////////////////////////////////////////////////////////////////

  assign coeff = fir_pkg::coeff_table[base_index + int'(slot_info.slot)];

  assign mul_full = tap * coeff;  // sfix32_En31
  assign product  = mul_full[fir_pkg::product_w-1:0];

  // sign extend to accumulator width
  assign product_ext = {{(fir_pkg::acc_w - fir_pkg::product_w){product[fir_pkg::product_w-1]}},
                        product};

  assign acc_sum = acc_q + product_ext;

  ////////////////////////////////////////////////////////////////////////////
  // accumulator
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      acc_q <= '0;
    end else if (slot_info.first) begin
      acc_q <= product_ext;  // new frame
    end else if (slot_info.en) begin
      acc_q <= acc_sum;
    end
  end

  assign acc = acc_q;

endmodule

`default_nettype wire

//--- rtl/tap_delay_line.sv
`timescale 1ns/1ps
`default_nettype none

module tap_delay_line #(
  parameter int num_lanes     = 2,
  parameter int taps_per_lane = 4
) (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   clk_enable,
  input  fir_pkg::sample_t                       filter_in,
  output fir_pkg::slot_info_t                    slot_info,
  output fir_pkg::sample_t [num_lanes-1:0]       lane_taps
);

  localparam int total_taps = num_lanes * taps_per_lane;
  localparam fir_pkg::slot_t last_slot = fir_pkg::slot_t'(taps_per_lane - 1);

  fir_pkg::slot_t                    slot;
  fir_pkg::sample_t [total_taps-1:0] delay_line;  // tap 0 is the newest sample
  logic                              first;
  logic                              last;

  ////////////////////////////////////////////////////////////////////////////
  // slot counter
  ////////////////////////////////////////////////////////////////////////////

  // starts on the last slot so the first enabled edge captures a sample
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      slot <= last_slot;
    end else if (clk_enable) begin
      if (slot >= last_slot) begin
        slot <= '0;
      end else begin
        slot <= slot + fir_pkg::slot_t'(1);
      end
    end
  end

  assign first = clk_enable && (slot == '0);
  assign last  = clk_enable && (slot == last_slot);

  always_comb begin
    slot_info.slot  = slot;
    slot_info.first = first;
    slot_info.last  = last;
    slot_info.en    = clk_enable;
  end

  ////////////////////////////////////////////////////////////////////////////
  // sample delay line
  ////////////////////////////////////////////////////////////////////////////

  // one shift per frame, on the last slot
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      delay_line <= '0;
    end else if (last) begin
      delay_line[0] <= filter_in;
      for (int i = 1; i < total_taps; i++) begin
        delay_line[i] <= delay_line[i-1];
      end
    end
  end

  // each lane walks its own group of taps
  always_comb begin
    for (int l = 0; l < num_lanes; l++) begin
      lane_taps[l] = delay_line[l * taps_per_lane + int'(slot)];
    end
  end

endmodule

`default_nettype wire

//--- rtl/fir_pkg.sv
`default_nettype none

package fir_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int sample_w  = 16;  // Q1.15 input
  localparam int coeff_w   = 16;  // 16 fraction bits
  localparam int product_w = 31;  // 31 fraction bits kept
  localparam int acc_w     = 33;  // accumulators and output
  localparam int slot_w    = 2;

  typedef logic signed [sample_w-1:0] sample_t;
  typedef logic signed [coeff_w-1:0]  coeff_t;
  typedef logic signed [acc_w-1:0]    acc_t;
  typedef logic [slot_w-1:0]          slot_t;

  ////////////////////////////////////////////////////////////////////////////
  // coefficients
  ////////////////////////////////////////////////////////////////////////////

  localparam int num_coeffs = 8;

  // symmetric low-pass, tap order, sfix16_En16
  localparam coeff_t coeff_table [num_coeffs] = '{
    16'hDDBB,
    16'hEA8E,
    16'h33DB,
    16'h6808,
    16'h6808,
    16'h33DB,
    16'hEA8E,
    16'hDDBB
  };

  ////////////////////////////////////////////////////////////////////////////
  // slot phase, shared by feeder, lanes and combiner
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    slot_t slot;   // tap slot within the frame
    logic  first;  // slot 0 and enabled
    logic  last;   // final slot and enabled
    logic  en;     // clk_enable
  } slot_info_t;

endpackage

`default_nettype wire
